// File: verilog.f
hw/mips_pkg.sv
hw/maindec.sv
hw/regfile.sv
hw/branch_unit.sv
hw/decode_stage.sv
tests/decode_stage_assert.sv
tests/decode_stage_tb.sv

// File: tests/decode_stage_tb.sv
`default_nettype none

module decode_stage_tb import mips_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int  MAX_CYCLES = 400;  // About 150 cycles of tests plus margin
    localparam wb_t NO_WB      = '0;

    logic   clk         = 1'b0;
    logic   rst_n       = 1'b0;
    logic   instr_valid = 1'b0;
    word_t  instr       = '0;
    word_t  pc          = '0;
    logic   stall       = 1'b0;
    wb_t    wb          = '0;
    id_ex_t id_ex;
    word_t  shadow [32];
    word_t  next_pc = 32'h9000_0400;
    int     seed    = 73894;
    int     cycles  = 0;

    decode_stage decode_stage_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .pc          (pc),
        .stall       (stall),
        .wb          (wb),
        .id_ex       (id_ex)
    );

    always #4 clk = ~clk;

    task automatic abort_run(input string why);
        if (why.len() > 0) begin
            $display("%s", why);
        end
        $display(">>> FAIL");
        $fatal(1, "Simulation stopped on error");
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            abort_run("Timeout: the run did not finish within the cycle limit");
        end else if (decode_stage_inst.decode_stage_assert_inst.fails != 0) begin
            abort_run("A bound assertion on the decode stage failed");
        end
    end

    task automatic check_word(input string name, input word_t got, input word_t exp);
        assert (got === exp) else begin
            $display("CHECK FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
            abort_run("");
        end
    endtask

    function automatic word_t r_type(input reg_addr_t rs, input reg_addr_t rt,
                                     input reg_addr_t rd, input logic [4:0] sh, input func_t f);
        return {OP_RT, rs, rt, rd, sh, f};
    endfunction

    function automatic word_t i_type(input op_t o, input reg_addr_t rs, input reg_addr_t rt,
                                     input logic [15:0] im);
        return {o, rs, rt, im};
    endfunction

    function automatic wb_t wb_of(input reg_addr_t a, input word_t d);
        return '{en: 1'b1, addr: a, data: d};
    endfunction

    // Flag bits from the top are shamt_valid, branch, branch1, branch2, jump, jr, memtoreg,
    // hiwrite, lowrite, hitoreg, lotoreg, cp0write, cp0toreg, is_eret, is_bp and is_sys
    function automatic logic [15:0] flags_of(input decoded_op_t o);
        logic [15:0] f;
        f = '0;
        case (o)
            SLL, SRL, SRA:               f[15] = 1'b1;
            BEQ, BNE:                    f[14:12] = 3'b101;
            BGEZ, BLTZ, BGEZAL, BLTZAL,
            BGTZ, BLEZ:                  f[14:12] = 3'b110;
            J, JAL:                      f[11] = 1'b1;
            JR, JALR:                    f[11:10] = 2'b11;
            LB, LBU, LH, LHU, LW:        f[9] = 1'b1;
            MULT, MULTU, DIV, DIVU:      f[8:7] = 2'b11;
            MTHI:                        f[8] = 1'b1;
            MTLO:                        f[7] = 1'b1;
            MFHI:                        f[6] = 1'b1;
            MFLO:                        f[5] = 1'b1;
            MTC0:                        f[4] = 1'b1;
            MFC0:                        f[3] = 1'b1;
            ERET:                        f[2] = 1'b1;
            BREAK:                       f[1] = 1'b1;
            SYSCALL:                     f[0] = 1'b1;
            default:                     f = '0;
        endcase
        return f;
    endfunction

    task automatic write_reg(input reg_addr_t a, input word_t d);
        @(posedge clk);
        wb <= wb_of(a, d);
        if (a != 5'd0) begin
            shadow[a] = d;  // r0 stays zero
        end
    endtask

    task automatic issue(input word_t ins, input decoded_op_t exp_op, input logic exp_wr,
                         input logic exp_mw, input reg_addr_t exp_dst, input wb_t w);
        word_t       exp_rs;
        word_t       exp_rt;
        word_t       exp_imm;
        word_t       exp_tgt;
        word_t       pc4;
        logic        exp_tk;
        logic        is_br;
        logic [15:0] got_flags;
        @(posedge clk);
        instr       <= ins;
        pc          <= next_pc;
        instr_valid <= 1'b1;
        stall       <= 1'b0;
        wb          <= w;
        if (w.en && w.addr != 5'd0) begin
            shadow[w.addr] = w.data;  // Same-cycle writeback is visible to the read
        end
        exp_rs = shadow[ins[25:21]];
        exp_rt = shadow[ins[20:16]];
        case (ins[31:26])
            OP_ANDI, OP_ORI, OP_XORI: exp_imm = {16'h0000, ins[15:0]};
            OP_LUI:                   exp_imm = {ins[15:0], 16'h0000};
            default:                  exp_imm = {{16{ins[15]}}, ins[15:0]};
        endcase
        pc4     = next_pc + 32'd4;
        exp_tgt = pc4 + {{14{ins[15]}}, ins[15:0], 2'b00};
        exp_tk  = 1'b0;
        is_br   = 1'b1;
        case (ins[31:26])
            OP_BEQ:       exp_tk = (exp_rs == exp_rt);
            OP_BNE:       exp_tk = (exp_rs != exp_rt);
            OP_BGTZ:      exp_tk = ($signed(exp_rs) > 0);
            OP_BLEZ:      exp_tk = ($signed(exp_rs) <= 0);
            OP_BGEZ:      exp_tk = ins[16] ? !exp_rs[31] : exp_rs[31];  // rt bit 0 picks GEZ
            OP_J, OP_JAL: begin
                exp_tk  = 1'b1;
                exp_tgt = {pc4[31:28], ins[25:0], 2'b00};
            end
            OP_RT: begin
                is_br   = (ins[5:1] == 5'b00100);  // JR and JALR
                exp_tk  = is_br;
                exp_tgt = exp_rs;
            end
            default:      is_br = 1'b0;
        endcase
        is_br  = is_br && (exp_op != RESERVED);
        exp_tk = exp_tk && is_br;
        @(posedge clk);
        instr_valid <= 1'b0;
        wb          <= NO_WB;
        @(negedge clk);
        got_flags = {id_ex.ctl.shamt_valid, id_ex.ctl.branch, id_ex.ctl.branch1,
                     id_ex.ctl.branch2, id_ex.ctl.jump, id_ex.ctl.jr, id_ex.ctl.memtoreg,
                     id_ex.ctl.hiwrite, id_ex.ctl.lowrite, id_ex.ctl.hitoreg,
                     id_ex.ctl.lotoreg, id_ex.ctl.cp0write, id_ex.ctl.cp0toreg,
                     id_ex.ctl.is_eret, id_ex.ctl.is_bp, id_ex.ctl.is_sys};
        check_word("id_ex.valid", 32'(id_ex.valid), 32'd1);
        check_word("id_ex.pc", id_ex.pc, next_pc);
        check_word("id_ex.op", 32'(id_ex.op), 32'(exp_op));
        check_word("id_ex.exception_ri", 32'(id_ex.exception_ri), 32'(exp_op == RESERVED));
        check_word("id_ex.ctl.regwrite", 32'(id_ex.ctl.regwrite), 32'(exp_wr));
        check_word("id_ex.ctl.memwrite", 32'(id_ex.ctl.memwrite), 32'(exp_mw));
        check_word("id_ex.ctl flags", 32'(got_flags), 32'(flags_of(exp_op)));
        check_word("id_ex.rs_val", id_ex.rs_val, exp_rs);
        check_word("id_ex.rt_val", id_ex.rt_val, exp_rt);
        check_word("id_ex.imm", id_ex.imm, exp_imm);
        check_word("id_ex.shamt", 32'(id_ex.shamt), 32'(ins[10:6]));
        if (exp_wr) begin
            check_word("id_ex.dst", 32'(id_ex.dst), 32'(exp_dst));
        end
        check_word("id_ex.branch_taken", 32'(id_ex.branch_taken), 32'(exp_tk));
        if (is_br) begin
            check_word("id_ex.target", id_ex.target, exp_tgt);
        end
        next_pc = pc4;
    endtask

    task automatic stall_burst(input int n);
        id_ex_t held;
        word_t  b_pc;
        @(posedge clk);
        instr       <= i_type(OP_ORI, 5'd7, 5'd8, 16'h00ff);
        pc          <= next_pc;
        instr_valid <= 1'b1;
        stall       <= 1'b0;
        wb          <= NO_WB;
        @(posedge clk);
        b_pc = next_pc + 32'd4;
        instr <= i_type(OP_XORI, 5'd9, 5'd10, 16'h5a5a);
        pc    <= b_pc;
        stall <= 1'b1;
        @(negedge clk);
        held = id_ex;
        check_word("id_ex.pc", id_ex.pc, next_pc);
        repeat (n) begin
            @(negedge clk);
            assert (id_ex === held) else begin
                $display("CHECK FAILED at %0t: id_ex = %h, expected %h", $time, id_ex, held);
                abort_run("");
            end
        end
        @(posedge clk);
        stall <= 1'b0;
        @(posedge clk);
        instr_valid <= 1'b0;
        @(negedge clk);
        check_word("id_ex.pc", id_ex.pc, b_pc);  // Held instruction taken once stall drops
        next_pc = b_pc + 32'd4;
    endtask

    initial begin
        shadow = '{default: '0};
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        for (int r = 1; r < 32; r++) begin
            write_reg(r[4:0], $random(seed));
        end
        write_reg(5'd20, 32'hffff_fffb);
        write_reg(5'd21, 32'h0000_0000);
        write_reg(5'd22, 32'h0000_0007);
        write_reg(5'd0, 32'hdead_beef);
        @(negedge clk);
        check_word("id_ex.valid", 32'(id_ex.valid), 32'd0);
        issue(r_type(5'd1, 5'd2, 5'd3, 5'd0, F_ADD), ADD, 1'b1, 1'b0, 5'd3, NO_WB);
        issue(r_type(5'd4, 5'd5, 5'd6, 5'd0, F_SUBU), SUBU, 1'b1, 1'b0, 5'd6, NO_WB);
        issue(r_type(5'd7, 5'd8, 5'd9, 5'd0, F_SLT), SLT, 1'b1, 1'b0, 5'd9, NO_WB);
        issue(r_type(5'd0, 5'd13, 5'd14, 5'd7, F_SLL), SLL, 1'b1, 1'b0, 5'd14, NO_WB);
        issue(r_type(5'd15, 5'd16, 5'd17, 5'd0, F_SRAV), SRAV, 1'b1, 1'b0, 5'd17, NO_WB);
        issue(r_type(5'd18, 5'd19, 5'd0, 5'd0, F_MULT), MULT, 1'b0, 1'b0, 5'd0, NO_WB);
        issue(r_type(5'd0, 5'd0, 5'd23, 5'd0, F_MFHI), MFHI, 1'b1, 1'b0, 5'd23, NO_WB);
        issue(r_type(5'd24, 5'd0, 5'd0, 5'd0, F_MTLO), MTLO, 1'b0, 1'b0, 5'd0, NO_WB);
        issue(r_type(5'd0, 5'd0, 5'd0, 5'd0, F_SYSCALL), SYSCALL, 1'b0, 1'b0, 5'd0, NO_WB);
        issue(r_type(5'd0, 5'd0, 5'd0, 5'd0, F_BREAK), BREAK, 1'b0, 1'b0, 5'd0, NO_WB);
        issue(i_type(OP_ADDI, 5'd3, 5'd4, 16'hfff0), ADD, 1'b1, 1'b0, 5'd4, NO_WB);
        issue(i_type(OP_SLTIU, 5'd5, 5'd6, 16'h8000), SLTU, 1'b1, 1'b0, 5'd6, NO_WB);
        issue(i_type(OP_ANDI, 5'd7, 5'd8, 16'h8001), AND, 1'b1, 1'b0, 5'd8, NO_WB);
        issue(i_type(OP_ORI, 5'd9, 5'd10, 16'hf0f0), OR, 1'b1, 1'b0, 5'd10, NO_WB);
        issue(i_type(OP_XORI, 5'd11, 5'd12, 16'hffff), XOR, 1'b1, 1'b0, 5'd12, NO_WB);
        issue(i_type(OP_LUI, 5'd0, 5'd13, 16'habcd), LUI, 1'b1, 1'b0, 5'd13, NO_WB);
        issue(i_type(OP_LW, 5'd14, 5'd15, 16'hfffc), LW, 1'b1, 1'b0, 5'd15, NO_WB);
        issue(i_type(OP_LBU, 5'd16, 5'd17, 16'h0003), LBU, 1'b1, 1'b0, 5'd17, NO_WB);
        issue(i_type(OP_SW, 5'd18, 5'd19, 16'h0010), SW, 1'b0, 1'b1, 5'd0, NO_WB);
        issue(i_type(OP_ERET, C_MFC0, 5'd25, 16'h6000), MFC0, 1'b1, 1'b0, 5'd25, NO_WB);
        issue(i_type(OP_ERET, C_MTC0, 5'd26, 16'h6000), MTC0, 1'b0, 1'b0, 5'd0, NO_WB);
        issue(i_type(OP_ERET, C_ERET, 5'd0, 16'h0018), ERET, 1'b0, 1'b0, 5'd0, NO_WB);
        issue(i_type(OP_BEQ, 5'd5, 5'd5, 16'h0010), BEQ, 1'b0, 1'b0, 5'd0, NO_WB);
        issue(i_type(OP_BEQ, 5'd5, 5'd6, 16'hfff8), BEQ, 1'b0, 1'b0, 5'd0, NO_WB);
        issue(i_type(OP_BNE, 5'd5, 5'd6, 16'hfff8), BNE, 1'b0, 1'b0, 5'd0, NO_WB);
        issue(i_type(OP_BNE, 5'd7, 5'd7, 16'h0004), BNE, 1'b0, 1'b0, 5'd0, NO_WB);
        issue(i_type(OP_BGEZ, 5'd22, B_BGEZ, 16'h0020), BGEZ, 1'b0, 1'b0, 5'd0, NO_WB);
        issue(i_type(OP_BGEZ, 5'd20, B_BGEZ, 16'h0020), BGEZ, 1'b0, 1'b0, 5'd0, NO_WB);
        issue(i_type(OP_BGEZ, 5'd20, B_BLTZ, 16'hff00), BLTZ, 1'b0, 1'b0, 5'd0, NO_WB);
        issue(i_type(OP_BGEZ, 5'd21, B_BGEZAL, 16'h0040), BGEZAL, 1'b1, 1'b0, 5'd31, NO_WB);
        issue(i_type(OP_BGEZ, 5'd22, B_BLTZAL, 16'h0040), BLTZAL, 1'b1, 1'b0, 5'd31, NO_WB);
        issue(i_type(OP_BGTZ, 5'd22, 5'd0, 16'h0008), BGTZ, 1'b0, 1'b0, 5'd0, NO_WB);
        issue(i_type(OP_BGTZ, 5'd21, 5'd0, 16'h0008), BGTZ, 1'b0, 1'b0, 5'd0, NO_WB);
        issue(i_type(OP_BLEZ, 5'd21, 5'd0, 16'hfffc), BLEZ, 1'b0, 1'b0, 5'd0, NO_WB);
        issue(i_type(OP_BLEZ, 5'd22, 5'd0, 16'hfffc), BLEZ, 1'b0, 1'b0, 5'd0, NO_WB);
        issue({OP_J, 26'h2a5_5a5a}, J, 1'b0, 1'b0, 5'd0, NO_WB);
        issue({OP_JAL, 26'h012_3456}, JAL, 1'b1, 1'b0, 5'd31, NO_WB);
        issue(r_type(5'd5, 5'd0, 5'd0, 5'd0, F_JR), JR, 1'b0, 1'b0, 5'd0, NO_WB);
        issue(r_type(5'd6, 5'd0, 5'd9, 5'd0, F_JALR), JALR, 1'b1, 1'b0, 5'd9, NO_WB);
        issue({6'b111111, 26'h0}, RESERVED, 1'b0, 1'b0, 5'd0, NO_WB);
        issue(r_type(5'd1, 5'd2, 5'd3, 5'd0, 6'b111111), RESERVED, 1'b0, 1'b0, 5'd0, NO_WB);
        issue(i_type(OP_BGEZ, 5'd1, 5'b00010, 16'h0004), RESERVED, 1'b0, 1'b0, 5'd0, NO_WB);
        issue(i_type(OP_ERET, 5'b00001, 5'd1, 16'h0), RESERVED, 1'b0, 1'b0, 5'd0, NO_WB);
        issue(r_type(5'd12, 5'd0, 5'd3, 5'd0, F_ADD), ADD, 1'b1, 1'b0, 5'd3,
              wb_of(5'd12, 32'hcafe_0012));
        issue(r_type(5'd0, 5'd0, 5'd3, 5'd0, F_OR), OR, 1'b1, 1'b0, 5'd3,
              wb_of(5'd0, 32'h1234_5678));
        stall_burst(4);
        repeat (3) @(posedge clk);
        @(negedge clk);
        if (decode_stage_inst.decode_stage_assert_inst.fails == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            abort_run("A bound assertion on the decode stage failed");
        end
    end

endmodule

`default_nettype wire

// File: tests/decode_stage_assert.sv
`default_nettype none

module decode_stage_assert import mips_pkg::*; (
    input logic   clk,
    input logic   rst_n,
    input logic   instr_valid,
    input logic   stall,
    input word_t  pc,
    input id_ex_t id_ex
);

    timeunit 1ns;
    timeprecision 100ps;

    int unsigned fails = 0;  // Read by the testbench top

    reset_clears_valid: assert property (@(posedge clk) !rst_n |=> !id_ex.valid)
        else begin $error("id_ex.valid set right after reset"); fails++; end

    accept_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        instr_valid && !stall |=> id_ex.valid && id_ex.pc == $past(pc))
        else begin $error("accepted instruction missing from id_ex"); fails++; end

    idle_clears_valid: assert property (@(posedge clk) disable iff (!rst_n)
        !instr_valid && !stall |=> !id_ex.valid)
        else begin $error("id_ex.valid set without an instruction"); fails++; end

    stall_holds: assert property (@(posedge clk) disable iff (!rst_n)
        stall |=> $stable(id_ex))
        else begin $error("id_ex changed during a stall"); fails++; end

    // Reserved encodings must not write any architectural state
    reserved_no_writes: assert property (@(posedge clk) disable iff (!rst_n)
        id_ex.valid && id_ex.exception_ri |-> id_ex.op == RESERVED
            && !id_ex.ctl.regwrite && !id_ex.ctl.memwrite && !id_ex.ctl.hiwrite
            && !id_ex.ctl.lowrite && !id_ex.ctl.cp0write)
        else begin $error("reserved instruction carries a write control"); fails++; end

    link_dst: assert property (@(posedge clk) disable iff (!rst_n)
        id_ex.valid && (id_ex.op == JAL || id_ex.op == BGEZAL || id_ex.op == BLTZAL)
            |-> id_ex.dst == 5'd31)
        else begin $error("link destination is not r31"); fails++; end

endmodule

bind decode_stage decode_stage_assert decode_stage_assert_inst (.*);

`default_nettype wire

// File: hw/decode_stage.sv
`default_nettype none

module decode_stage import mips_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   instr_valid,
    input  word_t  instr,
    input  word_t  pc,
    input  logic   stall,
    input  wb_t    wb,
    output id_ex_t id_ex
);

    decoded_op_t op;
    control_t    ctl;
    logic        exception_ri;
    word_t       rs_val;
    word_t       rt_val;
    word_t       imm;
    reg_addr_t   dst;
    logic        taken;
    word_t       target;
    id_ex_t      id_ex_d;

    maindec maindec_inst (
        .instr        (instr),
        .op           (op),
        .exception_ri (exception_ri),
        .ctl          (ctl)
    );

    regfile regfile_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .ra1   (instr[25:21]),
        .ra2   (instr[20:16]),
        .wb    (wb),
        .rd1   (rs_val),
        .rd2   (rt_val)
    );

    branch_unit branch_unit_inst (
        .ctl    (ctl),
        .pc     (pc),
        .instr  (instr),
        .rs_val (rs_val),
        .rt_val (rt_val),
        .taken  (taken),
        .target (target)
    );

    always_comb begin
        if (ctl.zeroext) begin
            imm = {16'h0000, instr[15:0]};
        end else if (op == LUI) begin
            imm = {instr[15:0], 16'h0000};
        end else begin
            imm = {{16{instr[15]}}, instr[15:0]};
        end
    end

    always_comb begin
        case (ctl.regdst)
            RD:      dst = instr[15:11];
            RA:      dst = 5'd31;
            default: dst = instr[20:16];
        endcase
    end

    always_comb begin
        id_ex_d              = '0;
        id_ex_d.valid        = instr_valid;
        id_ex_d.pc           = pc;
        id_ex_d.op           = op;
        id_ex_d.ctl          = ctl;
        id_ex_d.exception_ri = exception_ri;
        id_ex_d.rs_val       = rs_val;
        id_ex_d.rt_val       = rt_val;
        id_ex_d.imm          = imm;
        id_ex_d.shamt        = instr[10:6];
        id_ex_d.dst          = dst;
        id_ex_d.branch_taken = taken;
        id_ex_d.target       = target;
    end

    // A stall freezes the whole bundle while the source keeps presenting the instruction
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            id_ex.valid <= 1'b0;
        end else if (!stall) begin
            id_ex <= id_ex_d;
        end
    end

endmodule

`default_nettype wire

// File: hw/branch_unit.sv
`default_nettype none

module branch_unit import mips_pkg::*; (
    input  control_t ctl,
    input  word_t    pc,
    input  word_t    instr,
    input  word_t    rs_val,
    input  word_t    rt_val,
    output logic     taken,
    output word_t    target
);

    word_t pc_plus4;
    word_t br_target;
    word_t j_target;
    logic  cond;

    assign pc_plus4  = pc + 32'd4;
    assign br_target = pc_plus4 + {{14{instr[15]}}, instr[15:0], 2'b00};
    assign j_target  = {pc_plus4[31:28], instr[25:0], 2'b00};  // Stays in the current 256 MB region

    always_comb begin
        case (ctl.branch_type)
            T_BEQ:   cond = (rs_val == rt_val);
            T_BNE:   cond = (rs_val != rt_val);
            T_BGEZ:  cond = ($signed(rs_val) >= 0);
            T_BLTZ:  cond = ($signed(rs_val) < 0);
            T_BGTZ:  cond = ($signed(rs_val) > 0);
            T_BLEZ:  cond = ($signed(rs_val) <= 0);
            default: cond = 1'b0;
        endcase
    end

    assign taken = ctl.jump || (ctl.branch && cond);

    always_comb begin
        if (ctl.branch) begin
            target = br_target;
        end else if (ctl.jr) begin
            target = rs_val;
        end else if (ctl.jump) begin
            target = j_target;
        end else begin
            target = br_target;
        end
    end

endmodule

`default_nettype wire

// File: hw/regfile.sv
`default_nettype none

module regfile import mips_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  reg_addr_t ra1,
    input  reg_addr_t ra2,
    input  wb_t       wb,
    output word_t     rd1,
    output word_t     rd2
);

    word_t regs [32];

    function automatic word_t read_port(input reg_addr_t ra, input word_t stored, input wb_t w);
        if (ra == '0) begin
            return '0;
        end
        if (w.en && w.addr == ra) begin
            return w.data;  // Writeback in this cycle wins over the stored word
        end
        return stored;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            regs <= '{default: '0};
        end else if (wb.en && wb.addr != '0) begin
            regs[wb.addr] <= wb.data;
        end
    end

    assign rd1 = read_port(ra1, regs[ra1], wb);
    assign rd2 = read_port(ra2, regs[ra2], wb);

endmodule

`default_nettype wire

// File: hw/maindec.sv
`default_nettype none

module maindec import mips_pkg::*; (
    input  word_t       instr,
    output decoded_op_t op,
    output logic        exception_ri,
    output control_t    ctl
);

    op_t        opcode;
    func_t      func;
    logic [4:0] rs_field;
    logic [4:0] rt_field;
    logic       is_special;

    assign opcode     = instr[31:26];
    assign func       = instr[5:0];
    assign rs_field   = instr[25:21];
    assign rt_field   = instr[20:16];
    assign is_special = (opcode == OP_RT);

    function automatic alufunc_t alu_of(input decoded_op_t o);
        case (o)
            ADD:        return ALU_ADD;
            ADDU:       return ALU_ADDU;
            SUB:        return ALU_SUB;
            SUBU:       return ALU_SUBU;
            SLT:        return ALU_SLT;
            SLTU:       return ALU_SLTU;
            AND:        return ALU_AND;
            OR:         return ALU_OR;
            XOR:        return ALU_XOR;
            NOR:        return ALU_NOR;
            LUI:        return ALU_LUI;
            SLL, SLLV:  return ALU_SLL;
            SRL, SRLV:  return ALU_SRL;
            SRA, SRAV:  return ALU_SRA;
            default:    return ALU_PASSA;
        endcase
    endfunction

    always_comb begin
        op = RESERVED;
        case (opcode)
            OP_RT: begin
                case (func)
                    F_ADD:     op = ADD;
                    F_ADDU:    op = ADDU;
                    F_SUB:     op = SUB;
                    F_SUBU:    op = SUBU;
                    F_SLT:     op = SLT;
                    F_SLTU:    op = SLTU;
                    F_AND:     op = AND;
                    F_OR:      op = OR;
                    F_XOR:     op = XOR;
                    F_NOR:     op = NOR;
                    F_SLL:     op = SLL;
                    F_SRL:     op = SRL;
                    F_SRA:     op = SRA;
                    F_SLLV:    op = SLLV;
                    F_SRLV:    op = SRLV;
                    F_SRAV:    op = SRAV;
                    F_MULT:    op = MULT;
                    F_MULTU:   op = MULTU;
                    F_DIV:     op = DIV;
                    F_DIVU:    op = DIVU;
                    F_MFHI:    op = MFHI;
                    F_MFLO:    op = MFLO;
                    F_MTHI:    op = MTHI;
                    F_MTLO:    op = MTLO;
                    F_JR:      op = JR;
                    F_JALR:    op = JALR;
                    F_BREAK:   op = BREAK;
                    F_SYSCALL: op = SYSCALL;
                    default:   op = RESERVED;
                endcase
            end
            OP_BGEZ: begin
                case (rt_field)
                    B_BGEZ:   op = BGEZ;
                    B_BLTZ:   op = BLTZ;
                    B_BGEZAL: op = BGEZAL;
                    B_BLTZAL: op = BLTZAL;
                    default:  op = RESERVED;
                endcase
            end
            OP_ERET: begin
                case (rs_field)
                    C_ERET:  op = ERET;
                    C_MFC0:  op = MFC0;
                    C_MTC0:  op = MTC0;
                    default: op = RESERVED;
                endcase
            end
            OP_ADDI:  op = ADD;
            OP_ADDIU: op = ADDU;
            OP_SLTI:  op = SLT;
            OP_SLTIU: op = SLTU;
            OP_ANDI:  op = AND;
            OP_ORI:   op = OR;
            OP_XORI:  op = XOR;
            OP_LUI:   op = LUI;
            OP_BEQ:   op = BEQ;
            OP_BNE:   op = BNE;
            OP_BGTZ:  op = BGTZ;
            OP_BLEZ:  op = BLEZ;
            OP_J:     op = J;
            OP_JAL:   op = JAL;
            OP_LB:    op = LB;
            OP_LBU:   op = LBU;
            OP_LH:    op = LH;
            OP_LHU:   op = LHU;
            OP_LW:    op = LW;
            OP_SB:    op = SB;
            OP_SH:    op = SH;
            OP_SW:    op = SW;
            default:  op = RESERVED;
        endcase
    end

    assign exception_ri = (op == RESERVED);

    // ALU ops come from both SPECIAL and immediate forms, so the opcode picks operands
    always_comb begin
        ctl = '0;
        case (op)
            ADD, ADDU, SUB, SUBU, SLT, SLTU, AND, OR, XOR, NOR, LUI,
            SLL, SRL, SRA, SLLV, SRLV, SRAV: begin
                ctl.alufunc     = alu_of(op);
                ctl.regwrite    = 1'b1;
                ctl.regdst      = is_special ? RD : RT;
                ctl.alusrc      = is_special ? REGB : IMM;
                ctl.zeroext     = !is_special && (op inside {AND, OR, XOR});
                ctl.shamt_valid = op inside {SLL, SRL, SRA};
            end
            MULT, MULTU, DIV, DIVU: begin
                ctl.hiwrite = 1'b1;
                ctl.lowrite = 1'b1;
                ctl.alusrc  = REGB;
            end
            MFHI, MFLO: begin
                ctl.alufunc  = ALU_PASSA;
                ctl.regwrite = 1'b1;
                ctl.regdst   = RD;
                ctl.hitoreg  = (op == MFHI);
                ctl.lotoreg  = (op == MFLO);
            end
            MTHI, MTLO: begin
                ctl.alufunc = ALU_PASSA;
                ctl.hiwrite = (op == MTHI);
                ctl.lowrite = (op == MTLO);
            end
            BEQ, BNE: begin
                ctl.branch      = 1'b1;
                ctl.branch2     = 1'b1;
                ctl.branch_type = (op == BEQ) ? T_BEQ : T_BNE;
            end
            BGEZ, BGEZAL, BLTZ, BLTZAL: begin
                ctl.branch      = 1'b1;
                ctl.branch1     = 1'b1;
                ctl.branch_type = (op inside {BGEZ, BGEZAL}) ? T_BGEZ : T_BLTZ;
                ctl.regwrite    = op inside {BGEZAL, BLTZAL};  // Link writes pc+8 to r31
                ctl.regdst      = (op inside {BGEZAL, BLTZAL}) ? RA : RT;
            end
            BGTZ, BLEZ: begin
                ctl.branch      = 1'b1;
                ctl.branch1     = 1'b1;
                ctl.branch_type = (op == BGTZ) ? T_BGTZ : T_BLEZ;
            end
            J, JAL: begin
                ctl.jump     = 1'b1;
                ctl.regwrite = (op == JAL);
                ctl.regdst   = (op == JAL) ? RA : RT;
            end
            JR, JALR: begin
                ctl.alufunc  = ALU_PASSA;
                ctl.jump     = 1'b1;
                ctl.jr       = 1'b1;
                ctl.regwrite = (op == JALR);
                ctl.regdst   = RD;
            end
            LB, LBU, LH, LHU, LW: begin
                ctl.alufunc  = ALU_ADDU;
                ctl.regwrite = 1'b1;
                ctl.memtoreg = 1'b1;
                ctl.regdst   = RT;
                ctl.alusrc   = IMM;
            end
            SB, SH, SW: begin
                ctl.alufunc  = ALU_ADDU;
                ctl.memwrite = 1'b1;
                ctl.alusrc   = IMM;
            end
            MFC0: begin
                ctl.alufunc  = ALU_PASSA;
                ctl.regwrite = 1'b1;
                ctl.regdst   = RT;
                ctl.cp0toreg = 1'b1;
            end
            MTC0: begin
                ctl.alufunc  = ALU_PASSB;  // rt carries the value for CP0
                ctl.cp0write = 1'b1;
            end
            ERET:    ctl.is_eret = 1'b1;
            BREAK: begin
                ctl.alufunc = ALU_PASSA;
                ctl.is_bp   = 1'b1;
            end
            SYSCALL: begin
                ctl.alufunc = ALU_PASSA;
                ctl.is_sys  = 1'b1;
            end
            default: ctl.alufunc = ALU_PASSA;
        endcase
    end

endmodule

`default_nettype wire

// File: hw/mips_pkg.sv
`default_nettype none

package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [5:0]  op_t;
    typedef logic [5:0]  func_t;

    // Major opcodes
    localparam op_t OP_RT    = 6'b000000;  // SPECIAL group decoded by the function field
    localparam op_t OP_BGEZ  = 6'b000001;  // REGIMM group decoded by the rt field
    localparam op_t OP_J     = 6'b000010;
    localparam op_t OP_JAL   = 6'b000011;
    localparam op_t OP_BEQ   = 6'b000100;
    localparam op_t OP_BNE   = 6'b000101;
    localparam op_t OP_BLEZ  = 6'b000110;
    localparam op_t OP_BGTZ  = 6'b000111;
    localparam op_t OP_ADDI  = 6'b001000;
    localparam op_t OP_ADDIU = 6'b001001;
    localparam op_t OP_SLTI  = 6'b001010;
    localparam op_t OP_SLTIU = 6'b001011;
    localparam op_t OP_ANDI  = 6'b001100;
    localparam op_t OP_ORI   = 6'b001101;
    localparam op_t OP_XORI  = 6'b001110;
    localparam op_t OP_LUI   = 6'b001111;
    localparam op_t OP_ERET  = 6'b010000;  // COP0 group decoded by the rs field
    localparam op_t OP_LB    = 6'b100000;
    localparam op_t OP_LH    = 6'b100001;
    localparam op_t OP_LW    = 6'b100011;
    localparam op_t OP_LBU   = 6'b100100;
    localparam op_t OP_LHU   = 6'b100101;
    localparam op_t OP_SB    = 6'b101000;
    localparam op_t OP_SH    = 6'b101001;
    localparam op_t OP_SW    = 6'b101011;

    // Function field of SPECIAL
    localparam func_t F_SLL     = 6'b000000;
    localparam func_t F_SRL     = 6'b000010;
    localparam func_t F_SRA     = 6'b000011;
    localparam func_t F_SLLV    = 6'b000100;
    localparam func_t F_SRLV    = 6'b000110;
    localparam func_t F_SRAV    = 6'b000111;
    localparam func_t F_JR      = 6'b001000;
    localparam func_t F_JALR    = 6'b001001;
    localparam func_t F_SYSCALL = 6'b001100;
    localparam func_t F_BREAK   = 6'b001101;
    localparam func_t F_MFHI    = 6'b010000;
    localparam func_t F_MTHI    = 6'b010001;
    localparam func_t F_MFLO    = 6'b010010;
    localparam func_t F_MTLO    = 6'b010011;
    localparam func_t F_MULT    = 6'b011000;
    localparam func_t F_MULTU   = 6'b011001;
    localparam func_t F_DIV     = 6'b011010;
    localparam func_t F_DIVU    = 6'b011011;
    localparam func_t F_ADD     = 6'b100000;
    localparam func_t F_ADDU    = 6'b100001;
    localparam func_t F_SUB     = 6'b100010;
    localparam func_t F_SUBU    = 6'b100011;
    localparam func_t F_AND     = 6'b100100;
    localparam func_t F_OR      = 6'b100101;
    localparam func_t F_XOR     = 6'b100110;
    localparam func_t F_NOR     = 6'b100111;
    localparam func_t F_SLT     = 6'b101010;
    localparam func_t F_SLTU    = 6'b101011;

    // REGIMM rt field
    localparam logic [4:0] B_BLTZ   = 5'b00000;
    localparam logic [4:0] B_BGEZ   = 5'b00001;
    localparam logic [4:0] B_BLTZAL = 5'b10000;
    localparam logic [4:0] B_BGEZAL = 5'b10001;

    // COP0 rs field
    localparam logic [4:0] C_MFC0 = 5'b00000;
    localparam logic [4:0] C_MTC0 = 5'b00100;
    localparam logic [4:0] C_ERET = 5'b10000;

    typedef enum logic [5:0] {
        ADD, ADDU, SUB, SUBU, SLT, SLTU,
        AND, OR, XOR, NOR, LUI,
        SLL, SRL, SRA, SLLV, SRLV, SRAV,
        MULT, MULTU, DIV, DIVU, MFHI, MFLO, MTHI, MTLO,
        BEQ, BNE, BGEZ, BLTZ, BGEZAL, BLTZAL, BGTZ, BLEZ,
        J, JAL, JR, JALR,
        LB, LBU, LH, LHU, LW, SB, SH, SW,
        BREAK, SYSCALL, ERET, MFC0, MTC0,
        RESERVED
    } decoded_op_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU, ALU_SLT, ALU_SLTU,
        ALU_AND, ALU_OR, ALU_XOR, ALU_NOR, ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_LUI, ALU_PASSA, ALU_PASSB
    } alufunc_t;

    typedef enum logic [2:0] {
        T_BEQ, T_BNE, T_BGEZ, T_BLTZ, T_BGTZ, T_BLEZ
    } branch_type_t;

    typedef enum logic [1:0] {RT, RD, RA} regdst_t;

    typedef enum logic {REGB, IMM} alusrc_t;

    typedef struct packed {
        alufunc_t     alufunc;
        logic         regwrite;
        regdst_t      regdst;
        alusrc_t      alusrc;
        logic         zeroext;
        logic         memtoreg;
        logic         memwrite;
        logic         branch;
        logic         branch1;      // Compares rs against zero
        logic         branch2;      // Compares rs against rt
        branch_type_t branch_type;
        logic         jump;
        logic         jr;
        logic         hiwrite;
        logic         lowrite;
        logic         hitoreg;
        logic         lotoreg;
        logic         cp0write;
        logic         cp0toreg;
        logic         shamt_valid;
        logic         is_eret;
        logic         is_bp;
        logic         is_sys;
    } control_t;

    typedef struct packed {
        logic      en;
        reg_addr_t addr;
        word_t     data;
    } wb_t;

    typedef struct packed {
        logic        valid;
        word_t       pc;
        decoded_op_t op;
        control_t    ctl;
        logic        exception_ri;
        word_t       rs_val;
        word_t       rt_val;
        word_t       imm;
        logic [4:0]  shamt;
        reg_addr_t   dst;
        logic        branch_taken;
        word_t       target;
    } id_ex_t;

endpackage

`default_nettype wire
